// ==== verilog/beam_pkg.sv ====
`default_nettype none

package beam_pkg;

    // Array and sample format
    localparam int NUM_MICS = 4;
    localparam int SAMPLE_W = 12;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [NUM_MICS*SAMPLE_W-1:0] mic_bus_t; // Mic 0 in the low bits

    localparam int BUF_DEPTH = 16;
    typedef logic [$clog2(BUF_DEPTH)-1:0] buf_addr_t;

    localparam int MAX_DELAY = 7;
    typedef logic [$clog2(MAX_DELAY+1)-1:0] delay_t; // In sample frames

    // Image grid, row major
    localparam int GRID_COLS = 4;
    localparam int GRID_ROWS = 4;
    localparam int NUM_PIXELS = GRID_COLS * GRID_ROWS;
    typedef logic [$clog2(NUM_PIXELS)-1:0] pixel_t;

    typedef logic signed [SAMPLE_W+1:0] sum_t; // Four samples summed
    typedef logic [31:0] power_t;

    // Run lengths
    localparam int FILL_FRAMES = 8;
    localparam int ACC_FRAMES = 8;
    typedef logic [3:0] frame_cnt_t;

    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_FILL,
        RUN_ACCUM,
        RUN_DONE
    } run_state_t;

endpackage

`default_nettype wire

// ==== verilog/apb_map_pkg.sv ====
`default_nettype none

package apb_map_pkg;

    typedef logic [7:0] apb_addr_t;

    localparam apb_addr_t ADDR_CTRL = 8'h00;     // Bit 0 starts a run
    localparam apb_addr_t ADDR_STATUS = 8'h04;
    localparam apb_addr_t ADDR_MAP_BASE = 8'h40; // One word per pixel

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

endpackage

`default_nettype wire

// ==== verilog/image_ctrl_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module image_ctrl_fsm import beam_pkg::*; (
    input  wire logic       i_50M_clk,
    input  wire logic       i_rst,
    input  wire logic       i_start,
    input  wire frame_cnt_t i_frame_cnt,
    input  wire logic       i_scan_last,
    output run_state_t      o_state,
    output logic            o_cnt_clear,
    output logic            o_map_clear,
    output logic            o_scan_en,
    output logic            o_busy,
    output logic            o_done
);

    run_state_t state_r, state_w;
    logic [1:0] drain_cnt;
    logic start_ok;
    logic fill_end;

    assign start_ok = i_start && (state_r == RUN_IDLE || state_r == RUN_DONE); // Ignored when busy
    assign fill_end = (state_r == RUN_FILL) && (i_frame_cnt == frame_cnt_t'(FILL_FRAMES));

    assign o_cnt_clear = start_ok || fill_end;
    assign o_map_clear = start_ok;
    assign o_scan_en = (state_r == RUN_ACCUM) && (i_frame_cnt < frame_cnt_t'(ACC_FRAMES));
    assign o_busy = (state_r == RUN_FILL) || (state_r == RUN_ACCUM);
    assign o_done = (state_r == RUN_DONE);
    assign o_state = state_r;

    always_comb begin
        state_w = state_r;
        case (state_r)
            RUN_IDLE, RUN_DONE: if (start_ok) state_w = RUN_FILL;
            RUN_FILL: if (fill_end) state_w = RUN_ACCUM;
            RUN_ACCUM: if (drain_cnt == 2'd3) state_w = RUN_DONE;
            default: state_w = RUN_IDLE;
        endcase
    end

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= RUN_IDLE;
            drain_cnt <= '0;
        end else begin
            state_r <= state_w;
            // Wait for the final scan to reach the map
            if (state_r != RUN_ACCUM) drain_cnt <= '0;
            else if (drain_cnt != 2'd0) drain_cnt <= drain_cnt + 2'd1; // Wraps on leaving
            else if (i_scan_last && i_frame_cnt == frame_cnt_t'(ACC_FRAMES)) drain_cnt <= 2'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/scan_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module scan_timer import beam_pkg::*; (
    input  wire logic i_50M_clk,
    input  wire logic i_rst,
    input  wire logic i_sample_valid,
    input  wire logic i_cnt_clear,
    input  wire logic i_scan_en,
    output frame_cnt_t o_frame_cnt,
    output pixel_t     o_pixel,
    output logic       o_scan_valid,
    output logic       o_scan_last
);

    localparam pixel_t LAST_PIXEL = pixel_t'(NUM_PIXELS - 1);

    // Strobes since last clear
    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            o_frame_cnt <= '0;
        end else if (i_cnt_clear) begin
            o_frame_cnt <= '0;
        end else if (i_sample_valid && o_frame_cnt != '1) begin
            o_frame_cnt <= o_frame_cnt + frame_cnt_t'(1); // Saturates at 15
        end
    end

    // One pixel per cycle after a strobe
    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            o_scan_valid <= 1'b0;
            o_pixel <= '0;
        end else if (i_sample_valid && i_scan_en) begin
            o_scan_valid <= 1'b1;
            o_pixel <= '0;
        end else if (o_scan_valid) begin
            if (o_pixel == LAST_PIXEL) begin
                o_scan_valid <= 1'b0;
            end else begin
                o_pixel <= o_pixel + pixel_t'(1);
            end
        end
    end

    assign o_scan_last = o_scan_valid && (o_pixel == LAST_PIXEL);

endmodule

`default_nettype wire

// ==== verilog/mic_delay_line.sv ====
`timescale 1ns/1ns
`default_nettype none

module mic_delay_line import beam_pkg::*; #(
    parameter int MIC_IDX = 0
) (
    input  wire logic    i_50M_clk,
    input  wire logic    i_rst,
    input  wire logic    i_sample_valid,
    input  wire sample_t i_sample,
    input  wire pixel_t  i_pixel,
    input  wire logic    i_scan_valid,
    output sample_t      o_delayed,
    output logic         o_delayed_valid
);

    sample_t ring [BUF_DEPTH];
    buf_addr_t wr_ptr;
    buf_addr_t rd_addr;
    pixel_t row_idx;
    pixel_t col_idx;
    delay_t dly;

    // Fixed delay rule in place of geometry
    assign row_idx = i_pixel / pixel_t'(GRID_COLS);
    assign col_idx = i_pixel % pixel_t'(GRID_COLS);
    assign dly = delay_t'((MIC_IDX * col_idx + row_idx) % (MAX_DELAY + 1));

    assign rd_addr = wr_ptr - buf_addr_t'(dly) - buf_addr_t'(1); // Delay 0 is newest

    always_ff @(posedge i_50M_clk) begin
        if (i_sample_valid) ring[wr_ptr] <= i_sample;
    end

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
        end else if (i_sample_valid) begin
            wr_ptr <= wr_ptr + buf_addr_t'(1);
        end
    end

    always_ff @(posedge i_50M_clk) begin
        if (i_scan_valid) o_delayed <= ring[rd_addr];
    end

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) o_delayed_valid <= 1'b0;
        else o_delayed_valid <= i_scan_valid;
    end

endmodule

`default_nettype wire

// ==== verilog/power_accum.sv ====
`timescale 1ns/1ns
`default_nettype none

module power_accum import beam_pkg::*; (
    input  wire logic     i_50M_clk,
    input  wire logic     i_rst,
    input  wire logic     i_map_clear,
    input  wire mic_bus_t i_delayed,
    input  wire logic     i_delayed_valid,
    input  wire pixel_t   i_pixel_d,
    input  wire pixel_t   i_rd_pixel,
    output power_t        o_rd_power
);

    power_t map [NUM_PIXELS];
    sum_t beam_sum;
    logic signed [2*SAMPLE_W+3:0] beam_sq;
    power_t sq_r;
    logic sq_valid;
    pixel_t pix_q1;
    pixel_t pix_q2;

    always_comb begin
        beam_sum = '0;
        for (int m = 0; m < NUM_MICS; m++) begin
            beam_sum = beam_sum + sum_t'(sample_t'(i_delayed[m*SAMPLE_W +: SAMPLE_W]));
        end
    end

    assign beam_sq = beam_sum * beam_sum;

    // Pixel index follows the delay line and square stages
    always_ff @(posedge i_50M_clk) begin
        pix_q1 <= i_pixel_d;
        pix_q2 <= pix_q1;
        sq_r <= power_t'(beam_sq); // Never negative
    end

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) sq_valid <= 1'b0;
        else sq_valid <= i_delayed_valid;
    end

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int p = 0; p < NUM_PIXELS; p++) map[p] <= '0;
        end else if (i_map_clear) begin
            for (int p = 0; p < NUM_PIXELS; p++) map[p] <= '0;
        end else if (sq_valid) begin
            map[pix_q2] <= map[pix_q2] + sq_r;
        end
    end

    assign o_rd_power = map[i_rd_pixel];

endmodule

`default_nettype wire

// ==== verilog/apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_regs import beam_pkg::*, apb_map_pkg::*; (
    input  wire logic        i_50M_clk,
    input  wire logic        i_rst,
    input  wire logic        i_psel,
    input  wire logic        i_penable,
    input  wire logic        i_pwrite,
    input  wire apb_addr_t   i_paddr,
    input  wire logic [31:0] i_pwdata,
    output logic [31:0]      o_prdata,
    output logic             o_pready,
    output logic             o_pslverr,
    input  wire logic        i_busy,
    input  wire logic        i_done,
    output logic             o_start,
    output pixel_t           o_rd_pixel,
    input  wire power_t      i_rd_power
);

    logic access;
    logic in_map;
    logic [31:0] status;

    assign access = i_psel && i_penable; // Zero wait states
    assign o_pready = 1'b1;
    assign o_pslverr = 1'b0;

    // Map window 0x40..0x7C, word aligned
    assign in_map = (i_paddr[7:6] == ADDR_MAP_BASE[7:6]) && (i_paddr[1:0] == 2'b00);
    assign o_rd_pixel = pixel_t'(i_paddr[5:2]);

    always_comb begin
        status = '0;
        status[STAT_BUSY_BIT] = i_busy;
        status[STAT_DONE_BIT] = i_done;
    end

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) o_start <= 1'b0;
        else o_start <= access && i_pwrite && (i_paddr == ADDR_CTRL) && i_pwdata[0];
    end

    always_comb begin
        o_prdata = '0; // Unmapped reads as zero
        if (access && !i_pwrite) begin
            if (i_paddr == ADDR_STATUS) o_prdata = status;
            else if (in_map) o_prdata = i_rd_power;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/beam_imager_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module beam_imager_top import beam_pkg::*, apb_map_pkg::*; (
    input  wire logic        i_50M_clk,
    input  wire logic        i_rst,
    input  wire logic        i_sample_valid,
    input  wire mic_bus_t    i_mic_data,
    input  wire logic        i_psel,
    input  wire logic        i_penable,
    input  wire logic        i_pwrite,
    input  wire apb_addr_t   i_paddr,
    input  wire logic [31:0] i_pwdata,
    output logic [31:0]      o_prdata,
    output logic             o_pready,
    output logic             o_pslverr,
    output logic             o_done
);

    frame_cnt_t frame_cnt;
    pixel_t scan_pixel;
    pixel_t rd_pixel;
    power_t rd_power;
    mic_bus_t delayed_bus;
    logic [NUM_MICS-1:0] delayed_valid;
    logic start, busy, cnt_clear, map_clear, scan_en, scan_valid, scan_last;

    image_ctrl_fsm ctrl_i (
        .i_50M_clk(i_50M_clk), .i_rst(i_rst), .i_start(start),
        .i_frame_cnt(frame_cnt), .i_scan_last(scan_last), .o_state(),
        .o_cnt_clear(cnt_clear), .o_map_clear(map_clear), .o_scan_en(scan_en),
        .o_busy(busy), .o_done(o_done)
    );

    scan_timer scan_i (
        .i_50M_clk(i_50M_clk), .i_rst(i_rst), .i_sample_valid(i_sample_valid),
        .i_cnt_clear(cnt_clear), .i_scan_en(scan_en), .o_frame_cnt(frame_cnt),
        .o_pixel(scan_pixel), .o_scan_valid(scan_valid), .o_scan_last(scan_last)
    );

    for (genvar m = 0; m < NUM_MICS; m++) begin : g_mic
        mic_delay_line #(.MIC_IDX(m)) delay_i (
            .i_50M_clk(i_50M_clk), .i_rst(i_rst), .i_sample_valid(i_sample_valid),
            .i_sample(sample_t'(i_mic_data[m*SAMPLE_W +: SAMPLE_W])),
            .i_pixel(scan_pixel), .i_scan_valid(scan_valid),
            .o_delayed(delayed_bus[m*SAMPLE_W +: SAMPLE_W]),
            .o_delayed_valid(delayed_valid[m])
        );
    end

    power_accum accum_i (
        .i_50M_clk(i_50M_clk), .i_rst(i_rst), .i_map_clear(map_clear),
        .i_delayed(delayed_bus), .i_delayed_valid(&delayed_valid),
        .i_pixel_d(scan_pixel), .i_rd_pixel(rd_pixel), .o_rd_power(rd_power)
    );

    apb_regs regs_i (
        .i_50M_clk(i_50M_clk), .i_rst(i_rst), .i_psel(i_psel), .i_penable(i_penable),
        .i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata), .o_prdata(o_prdata),
        .o_pready(o_pready), .o_pslverr(o_pslverr), .i_busy(busy), .i_done(o_done),
        .o_start(start), .o_rd_pixel(rd_pixel), .i_rd_power(rd_power)
    );

endmodule

`default_nettype wire

// ==== verification/beam_imager_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module beam_imager_props import apb_map_pkg::*; (
    input wire logic      i_50M_clk,
    input wire logic      i_rst,
    input wire logic      i_sample_valid,
    input wire logic      i_psel,
    input wire logic      i_penable,
    input wire logic      i_pwrite,
    input wire apb_addr_t i_paddr,
    input wire logic      i_pslverr,
    input wire logic      i_done,
    input wire logic      i_start,
    input wire logic      i_busy
);

    logic [4:0] strobe_gap; // Cycles since last strobe, saturating
    logic ctrl_wr;

    assign ctrl_wr = i_psel && i_penable && i_pwrite && (i_paddr == ADDR_CTRL);

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) strobe_gap <= '1;
        else if (i_sample_valid) strobe_gap <= '0;
        else if (strobe_gap != '1) strobe_gap <= strobe_gap + 5'd1;
    end

    a_busy_from_ctrl: assert property (@(posedge i_50M_clk) disable iff (i_rst)
        $rose(i_busy) |-> $past(ctrl_wr, 2)) else $error("busy rose without a CTRL write");

    a_no_slverr: assert property (@(posedge i_50M_clk) disable iff (i_rst)
        !i_pslverr) else $error("pslverr asserted");

    a_strobe_gap: assert property (@(posedge i_50M_clk) disable iff (i_rst)
        i_sample_valid |-> strobe_gap >= 5'd19) else $error("strobes closer than 20 cycles");

    a_done_hold: assert property (@(posedge i_50M_clk) disable iff (i_rst)
        $fell(i_done) |-> $past(i_start)) else $error("done fell without a start");

endmodule

bind beam_imager_top beam_imager_props props_i (
    .i_50M_clk(i_50M_clk), .i_rst(i_rst), .i_sample_valid(i_sample_valid),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite), .i_paddr(i_paddr),
    .i_pslverr(o_pslverr), .i_done(o_done), .i_start(start), .i_busy(busy)
);

`default_nettype wire

// ==== verification/tb_beam_imager.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_beam_imager import beam_pkg::*, apb_map_pkg::*; ();

    localparam int DONE_TIMEOUT = 100;

    logic clk_50m, rst, sample_valid, psel, penable, pwrite;
    mic_bus_t mic_data;
    apb_addr_t paddr;
    logic [31:0] pwdata, prdata;
    logic pready, pslverr, done;

    sample_t hist [NUM_MICS][16]; // Samples of the current run, by frame
    int frame_idx;
    int errors;
    int checks;
    integer seed;

    beam_imager_top dut_i (
        .i_50M_clk(clk_50m), .i_rst(rst), .i_sample_valid(sample_valid),
        .i_mic_data(mic_data), .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready),
        .o_pslverr(pslverr), .o_done(done)
    );

    always #10 clk_50m = ~clk_50m;

    task automatic check_equal(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        checks++;
        if (exp_val !== act_val) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp_val, act_val);
        end
    endtask

    task automatic apb_access(input apb_addr_t addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int cycles;
        @(posedge clk_50m);
        #1;
        psel = 1'b1;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk_50m);
        #1;
        penable = 1'b1;
        cycles = 0;
        while (!pready && cycles < 8) begin
            @(posedge clk_50m);
            #1;
            cycles++;
        end
        if (!pready) begin
            errors++;
            $display("APB transfer at 0x%h never completed", addr);
        end
        #4 rdata = prdata; // Mid access phase
        check_equal("apb pslverr", 32'h0, 32'(pslverr));
        @(posedge clk_50m);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
        logic [31:0] ignored;
        apb_access(addr, 1'b1, data, ignored);
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
        apb_access(addr, 1'b0, 32'h0, data);
    endtask

    task automatic strobe(input mic_bus_t data);
        @(posedge clk_50m);
        #1;
        sample_valid = 1'b1;
        mic_data = data;
        for (int m = 0; m < NUM_MICS; m++)
            hist[m][frame_idx] = data[m*SAMPLE_W +: SAMPLE_W];
        frame_idx++;
        @(posedge clk_50m);
        #1;
        sample_valid = 1'b0;
    endtask

    task automatic send_frame(input mic_bus_t data);
        strobe(data);
        repeat (24) @(posedge clk_50m);
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge clk_50m);
            #1;
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("o_done did not rise within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    function automatic mic_bus_t make_frame(input logic rand_mode);
        if (!rand_mode) return {NUM_MICS{sample_t'(100)}};
        return mic_bus_t'({$random(seed), $random(seed)});
    endfunction

    // Delay (m*c + r) mod 8, sum of four, squared, over the accumulate frames
    function automatic power_t model_power(input int p);
        power_t acc;
        int sum, d, r, c;
        acc = '0;
        r = p / GRID_COLS;
        c = p % GRID_COLS;
        for (int k = FILL_FRAMES; k < FILL_FRAMES + ACC_FRAMES; k++) begin
            sum = 0;
            for (int m = 0; m < NUM_MICS; m++) begin
                d = (m * c + r) % (MAX_DELAY + 1);
                sum += int'(hist[m][k - d]);
            end
            acc += power_t'(sum * sum);
        end
        return acc;
    endfunction

    task automatic test_reset();
        logic [31:0] rd;
        check_equal("reset done", 32'h0, 32'(done));
        apb_read(ADDR_STATUS, rd);
        check_equal("reset status", 32'h0, rd);
        for (int p = 0; p < NUM_PIXELS; p++) begin
            apb_read(apb_addr_t'(ADDR_MAP_BASE + 4*p), rd);
            check_equal($sformatf("reset pixel %0d", p), 32'h0, rd);
        end
    endtask

    task automatic run_image(input string name, input logic rand_mode, input logic restart_mid);
        logic [31:0] rd;
        int cycles;
        frame_idx = 0;
        apb_write(ADDR_CTRL, 32'h1);
        apb_read(ADDR_STATUS, rd);
        check_equal({name, " busy"}, 32'h1 << STAT_BUSY_BIT, rd);
        apb_read(ADDR_MAP_BASE, rd);
        check_equal({name, " map cleared"}, 32'h0, rd);
        for (int f = 0; f < FILL_FRAMES + ACC_FRAMES - 1; f++) begin
            send_frame(make_frame(rand_mode));
            if (restart_mid && f == 10)
                apb_write(ADDR_CTRL, 32'h1); // Busy, must be ignored
        end
        check_equal({name, " done early"}, 32'h0, 32'(done));
        strobe(make_frame(rand_mode));
        wait_done(cycles);
        check_equal({name, " done latency"}, 32'd19, 32'(cycles));
        apb_read(ADDR_STATUS, rd);
        check_equal({name, " status done"}, 32'h1 << STAT_DONE_BIT, rd);
        for (int p = 0; p < NUM_PIXELS; p++) begin
            apb_read(apb_addr_t'(ADDR_MAP_BASE + 4*p), rd);
            check_equal($sformatf("%s pixel %0d", name, p),
                        rand_mode ? model_power(p) : 32'(ACC_FRAMES * 400 * 400), rd);
        end
    endtask

    task automatic test_unmapped();
        logic [31:0] rd;
        apb_read(8'h08, rd);
        check_equal("unmapped 0x08", 32'h0, rd);
        apb_read(8'h80, rd);
        check_equal("unmapped 0x80", 32'h0, rd);
        apb_read(8'h42, rd); // Inside the map window but unaligned
        check_equal("unmapped 0x42", 32'h0, rd);
    endtask

    initial begin
        seed = 32'h75d;
        errors = 0;
        checks = 0;
        frame_idx = 0;
        clk_50m = 1'b0;
        rst = 1'b1;
        sample_valid = 1'b0;
        mic_data = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (2) @(posedge clk_50m);
        #1;
        rst = 1'b0;
        test_reset();
        run_image("constant", 1'b0, 1'b0);
        run_image("random", 1'b1, 1'b0);
        test_unmapped();
        run_image("restart", 1'b1, 1'b1);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/beam_pkg.sv
verilog/apb_map_pkg.sv
verilog/image_ctrl_fsm.sv
verilog/scan_timer.sv
verilog/mic_delay_line.sv
verilog/power_accum.sv
verilog/apb_regs.sv
verilog/beam_imager_top.sv
verification/beam_imager_props.sv
verification/tb_beam_imager.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f list.f --top-module tb_beam_imager -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep "^Testbench passed$" > /dev/null \
    && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
